/* files.f */
src/tile_pkg.sv
src/nest4_counter.sv
src/tile_addr_gen.sv
src/tile_buffer.sv
src/tile_reader_top.sv
testbench/tile_checker.sv
testbench/tb_tile_reader.sv

/* run.sh */
#!/bin/sh
# Builds the tile reader testbench with Verilator, runs it and
# decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

TOP=tb_tile_reader
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f files.f --top-module "$TOP" \
    --Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

grep -qx 'All tests passed!' "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass message not found in $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0

/* src/nest4_counter.sv */
// ############################
// Four-level nested loop counter
// Walks a 4-D tile with cnt0 as the
// innermost loop. Rests in an idle
// state with every counter at its
// bound until the first step.
// ############################

`timescale 1ns/1ps

module nest4_counter #(
    parameter int unsigned n0_max = 4,
    parameter int unsigned n1_max = 2,
    parameter int unsigned n2_max = 2,
    parameter int unsigned n3_max = 3
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           ena,
    input  logic           clean,
    output tile_pkg::cnt_t cnt0,
    output tile_pkg::cnt_t cnt1,
    output tile_pkg::cnt_t cnt2,
    output tile_pkg::cnt_t cnt3,
    output logic           idle,
    output logic           last
);
    import tile_pkg::*;

    // Loop bounds with level 0 in the lowest slot.
    localparam logic [3:0][cnt_w-1:0] max_val = {
        cnt_t'(n3_max),
        cnt_t'(n2_max),
        cnt_t'(n1_max),
        cnt_t'(n0_max)
    };

    // Last value of each loop before it wraps.
    localparam logic [3:0][cnt_w-1:0] top_val = {
        cnt_t'(n3_max - 1),
        cnt_t'(n2_max - 1),
        cnt_t'(n1_max - 1),
        cnt_t'(n0_max - 1)
    };

    logic [3:0][cnt_w-1:0] cnt_q;  // Counter state with level 0 innermost.
    logic [4:0]            carry;  // carry[i] enables a step of level i.

    // Carry chain. Level i steps when every inner level sits at its top
    // value, and carry[4] is the full flag of the whole walk.
    always_comb begin
        carry[0] = 1'b1;
        for (int i = 0; i < 4; i++) begin
            carry[i+1] = carry[i] && (cnt_q[i] == top_val[i]);
        end
    end

    // Idle means every counter rests at its bound.
    assign idle = (cnt_q == max_val);
    assign last = carry[4];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_q <= max_val;
        end else if (clean) begin
            cnt_q <= max_val;               // Back to idle.
        end else if (ena) begin
            if (idle) begin
                cnt_q <= '0;                // First step loads point 0.
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (carry[i]) begin
                        // Wrap at the top value, otherwise count up.
                        cnt_q[i] <= carry[i+1] ? '0 : cnt_q[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign cnt0 = cnt_q[0];
    assign cnt1 = cnt_q[1];
    assign cnt2 = cnt_q[2];
    assign cnt3 = cnt_q[3];

endmodule

/* src/tile_addr_gen.sv */
// ############################
// Strided tile address generator
// Maps a loop point to a buffer
// address from the tile origin and
// three strides, one cycle later.
// ############################

`timescale 1ns/1ps

module tile_addr_gen #(
    parameter int unsigned stride1 = 16,
    parameter int unsigned stride2 = 32,
    parameter int unsigned stride3 = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            ena,
    input  tile_pkg::cnt_t  cnt0,
    input  tile_pkg::cnt_t  cnt1,
    input  tile_pkg::cnt_t  cnt2,
    input  tile_pkg::cnt_t  cnt3,
    input  logic            idle,
    input  logic            last,
    input  tile_pkg::addr_t base_addr,
    output logic            rd_en,
    output tile_pkg::addr_t rd_addr,
    output logic            last_q
);
    import tile_pkg::*;

    logic        issue;     // Current point goes to the buffer.
    logic [31:0] offset;    // Point offset from the tile origin.
    addr_t       next_addr;

    // The idle step only loads the counters and reads nothing.
    assign issue = ena && !idle;

    // Innermost stride is always 1.
    assign offset = 32'(cnt0)
                  + 32'(cnt1) * stride1
                  + 32'(cnt2) * stride2
                  + 32'(cnt3) * stride3;

    assign next_addr = base_addr + offset[addr_w-1:0];  // Wraps modulo 256.

    always_ff @(posedge clk) begin
        if (issue) begin
            rd_addr <= next_addr;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_en  <= 1'b0;
            last_q <= 1'b0;
        end else begin
            rd_en <= issue;
            if (issue) begin
                last_q <= last;     // Rides along with the read.
            end
        end
    end

endmodule

/* src/tile_buffer.sv */
// ############################
// Tile buffer RAM
// 256 words, one write port and
// one registered read port.
// ############################

`timescale 1ns/1ps

module tile_buffer (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_en,
    input  tile_pkg::addr_t wr_addr,
    input  tile_pkg::data_t wr_data,
    input  logic            rd_en,
    input  tile_pkg::addr_t rd_addr,
    input  logic            last_in,
    output logic            rd_valid,
    output tile_pkg::data_t rd_data,
    output logic            tile_done
);
    import tile_pkg::*;

    data_t mem [0:2**addr_w-1];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];    // Holds between reads.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid  <= 1'b0;
            tile_done <= 1'b0;
        end else begin
            rd_valid  <= rd_en;
            tile_done <= rd_en && last_in;  // Marks the tile's last word.
        end
    end

endmodule

/* src/tile_pkg.sv */
// ############################
// Tile reader shared types
// Buffer address and word widths
// and the loop counter width used
// by the tile walk and its buffer.
// ############################

package tile_pkg;

    // Buffer geometry.
    localparam int addr_w = 8;      // 256 words.
    localparam int data_w = 16;     // One word per loop point.

    // Wide enough for any loop bound.
    localparam int cnt_w = 8;

    // A buffer address that wraps modulo 256.
    typedef logic [addr_w-1:0] addr_t;

    // A buffer word.
    typedef logic [data_w-1:0] data_t;

    // One loop counter value.
    typedef logic [cnt_w-1:0] cnt_t;

endpackage

/* src/tile_reader_top.sv */
// ############################
// Tile reader top level
// Nested loop counter, strided
// address generator and buffer RAM.
// Returns one word per loop point
// two cycles after its issue.
// ############################

`timescale 1ns/1ps

module tile_reader_top #(
    parameter int unsigned n0_max  = 4,
    parameter int unsigned n1_max  = 2,
    parameter int unsigned n2_max  = 2,
    parameter int unsigned n3_max  = 3,
    parameter int unsigned stride1 = 16,
    parameter int unsigned stride2 = 32,
    parameter int unsigned stride3 = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_en,
    input  tile_pkg::addr_t wr_addr,
    input  tile_pkg::data_t wr_data,
    input  tile_pkg::addr_t base_addr,
    input  logic            ena,
    input  logic            clean,
    output logic            rd_valid,
    output tile_pkg::data_t rd_data,
    output logic            tile_done
);
    import tile_pkg::*;

    cnt_t  cnt0;
    cnt_t  cnt1;
    cnt_t  cnt2;
    cnt_t  cnt3;
    logic  idle;
    logic  last;
    logic  rd_en;
    addr_t rd_addr;
    logic  last_q;

    nest4_counter #(
        .n0_max (n0_max),
        .n1_max (n1_max),
        .n2_max (n2_max),
        .n3_max (n3_max)
    ) nest4_counter_i (
        .clk   (clk),
        .rst   (rst),
        .ena   (ena),
        .clean (clean),
        .cnt0  (cnt0),
        .cnt1  (cnt1),
        .cnt2  (cnt2),
        .cnt3  (cnt3),
        .idle  (idle),
        .last  (last)
    );

    tile_addr_gen #(
        .stride1 (stride1),
        .stride2 (stride2),
        .stride3 (stride3)
    ) tile_addr_gen_i (
        .clk       (clk),
        .rst       (rst),
        .ena       (ena),
        .cnt0      (cnt0),
        .cnt1      (cnt1),
        .cnt2      (cnt2),
        .cnt3      (cnt3),
        .idle      (idle),
        .last      (last),
        .base_addr (base_addr),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .last_q    (last_q)
    );

    tile_buffer tile_buffer_i (
        .clk       (clk),
        .rst       (rst),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .last_in   (last_q),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .tile_done (tile_done)
    );

endmodule

/* testbench/tb_tile_reader.sv */
// ############################
// Tile reader testbench
// Fills the buffer, walks the tile
// with steady and random enables,
// and restarts it at random bases.
// ############################

`timescale 1ns/1ps

module tb_tile_reader;
    import tile_pkg::*;

    localparam int unsigned n0_max    = 4;
    localparam int unsigned n1_max    = 2;
    localparam int unsigned n2_max    = 2;
    localparam int unsigned n3_max    = 3;
    localparam int unsigned stride1   = 16;
    localparam int unsigned stride2   = 32;
    localparam int unsigned stride3   = 64;
    localparam int          tile_size = n0_max * n1_max * n2_max * n3_max;
    localparam int          wait_limit = 2000;

    logic        clk;
    logic        rst;
    logic        wr_en;
    addr_t       wr_addr;
    data_t       wr_data;
    addr_t       base_addr;
    logic        ena;
    logic        clean;
    logic        quiet;         // No output expected.
    logic        rd_valid;
    data_t       rd_data;
    logic        tile_done;
    int          word_count;
    int          mismatch_count;
    int          fault_count;
    int          timeout_count;
    logic [31:0] lfsr_state;

    always #5 clk = ~clk;

    // Fibonacci LFSR with taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic data_t fill_word(input addr_t a);
        return data_t'(a) * 16'h9e37 + 16'h1234;
    endfunction

    task automatic fill_buffer();
        for (int a = 0; a < 2**addr_w; a++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = addr_t'(a);
            wr_data = fill_word(addr_t'(a));
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // Steps the walk until the checker has seen target words.
    task automatic walk_words(input int target, input logic gaps);
        logic [31:0] r;
        int          cycles;
        cycles = 0;
        while (word_count < target && cycles < wait_limit) begin
            @(negedge clk);
            if (gaps) begin
                random_bits(1, r);
                ena = r[0];     // Random enable gap.
            end else begin
                ena = 1'b1;
            end
            cycles++;
        end
        if (word_count < target) begin
            $display("Timeout: only %0d of %0d words came back", word_count, target);
            timeout_count++;
        end
    endtask

    task automatic stop_and_drain();
        int idle_cycles;
        int cycles;
        ena = 1'b0;
        idle_cycles = 0;
        cycles = 0;
        while (idle_cycles < 3 && cycles < wait_limit) begin
            @(negedge clk);
            idle_cycles = rd_valid ? 0 : idle_cycles + 1;
            cycles++;
        end
        if (idle_cycles < 3) begin
            $display("Timeout: reads kept coming back after enable went low");
            timeout_count++;
        end
    endtask

    task automatic pulse_clean();
        @(negedge clk);
        clean = 1'b1;
        @(negedge clk);
        clean = 1'b0;
    endtask

    tile_reader_top #(
        .n0_max (n0_max), .n1_max (n1_max), .n2_max (n2_max), .n3_max (n3_max),
        .stride1 (stride1), .stride2 (stride2), .stride3 (stride3)
    ) tile_reader_top_i (
        .clk (clk), .rst (rst), .wr_en (wr_en), .wr_addr (wr_addr), .wr_data (wr_data),
        .base_addr (base_addr), .ena (ena), .clean (clean),
        .rd_valid (rd_valid), .rd_data (rd_data), .tile_done (tile_done)
    );

    tile_checker #(
        .n0_max (n0_max), .n1_max (n1_max), .n2_max (n2_max), .n3_max (n3_max),
        .stride1 (stride1), .stride2 (stride2), .stride3 (stride3)
    ) tile_checker_i (
        .clk (clk), .rst (rst), .clean (clean), .quiet (quiet), .base_addr (base_addr),
        .rd_valid (rd_valid), .rd_data (rd_data), .tile_done (tile_done),
        .word_count (word_count), .mismatch_count (mismatch_count),
        .fault_count (fault_count)
    );

    initial begin
        logic [31:0] r;
        clk           = 1'b0;
        rst           = 1'b1;
        wr_en         = 1'b0;
        wr_addr       = '0;
        wr_data       = '0;
        base_addr     = '0;
        ena           = 1'b0;
        clean         = 1'b0;
        quiet         = 1'b1;
        timeout_count = 0;
        lfsr_state    = 32'h8d9e;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fill_buffer();              // Outputs must stay low meanwhile.
        repeat (20) @(negedge clk);
        quiet = 1'b0;
        walk_words(2 * tile_size, 1'b0);    // Two full passes from base 0.
        stop_and_drain();
        walk_words(word_count + 70, 1'b1);
        stop_and_drain();
        // Restarts at bases high enough for the addresses to wrap.
        for (int round = 0; round < 3; round++) begin
            pulse_clean();
            random_bits(8, r);
            base_addr = addr_t'(r) | 8'h80;
            walk_words(word_count + tile_size + 10 * round + 5, 1'b1);
            stop_and_drain();
        end
        $display("Done: %0d words checked, %0d mismatches, %0d faults, %0d timeouts",
                 word_count, mismatch_count, fault_count, timeout_count);
        if (mismatch_count + fault_count + timeout_count == 0 && word_count > 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* testbench/tile_checker.sv */
// ############################
// Tile reader checker
// Watches the DUT ports and checks
// each returned word and done flag
// against the walk's loop order.
// ############################

`timescale 1ns/1ps

module tile_checker #(
    parameter int unsigned n0_max  = 4,
    parameter int unsigned n1_max  = 2,
    parameter int unsigned n2_max  = 2,
    parameter int unsigned n3_max  = 3,
    parameter int unsigned stride1 = 16,
    parameter int unsigned stride2 = 32,
    parameter int unsigned stride3 = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            clean,
    input  logic            quiet,
    input  tile_pkg::addr_t base_addr,
    input  logic            rd_valid,
    input  tile_pkg::data_t rd_data,
    input  logic            tile_done,
    output int              word_count,
    output int              mismatch_count,
    output int              fault_count
);
    import tile_pkg::*;

    localparam int unsigned tile_size = n0_max * n1_max * n2_max * n3_max;

    int unsigned point_idx;     // Next point expected from the walk.
    addr_t       exp_addr;
    data_t       exp_data;
    logic        exp_done;

    // Buffer fill pattern.
    function automatic data_t mem_word(input addr_t a);
        return data_t'(a) * 16'h9e37 + 16'h1234;
    endfunction

    // Address of point k with cnt0 as the innermost loop.
    function automatic addr_t point_addr(input addr_t base, input int unsigned k);
        int unsigned c0;
        int unsigned c1;
        int unsigned c2;
        int unsigned c3;
        int unsigned offs;
        c0 = k % n0_max;
        c1 = (k / n0_max) % n1_max;
        c2 = (k / (n0_max * n1_max)) % n2_max;
        c3 = k / (n0_max * n1_max * n2_max);
        offs = c0 + c1 * stride1 + c2 * stride2 + c3 * stride3;
        return base + addr_t'(offs);    // Wraps modulo 256.
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            point_idx      = 0;
            word_count     = 0;
            mismatch_count = 0;
            fault_count    = 0;
        end else begin
            if (quiet && (rd_valid !== 1'b0 || tile_done !== 1'b0)) begin
                $display("At %0t the reader returned output while it should be quiet", $time);
                fault_count++;
            end
            if (tile_done && !rd_valid) begin
                $display("At %0t tile_done was high without rd_valid", $time);
                fault_count++;
            end
            if (clean) begin
                if (rd_valid) begin
                    $display("At %0t a word came back during clean", $time);
                    fault_count++;
                end
                point_idx = 0;  // Walk restarts at point 0.
            end else if (rd_valid) begin
                exp_addr = point_addr(base_addr, point_idx);
                exp_data = mem_word(exp_addr);
                exp_done = (point_idx == tile_size - 1);
                if (rd_data !== exp_data) begin
                    $display("Mismatch at %0t: rd_data expected %h, actual %h (point %0d)",
                             $time, exp_data, rd_data, point_idx);
                    mismatch_count++;
                end
                if (tile_done !== exp_done) begin
                    $display("Mismatch at %0t: tile_done expected %b, actual %b (point %0d)",
                             $time, exp_done, tile_done, point_idx);
                    mismatch_count++;
                end
                word_count++;
                point_idx = (point_idx == tile_size - 1) ? 0 : point_idx + 1;
            end
        end
    end

endmodule
